/* logic/mmc5_pkg.sv */
// MMC5 mapper shared types, register map and timing constants
package mmc5_pkg;

	typedef logic [15:0] cpu_addr_t;  // CPU address bus
	typedef logic [7:0]  cpu_data_t;  // CPU data byte
	typedef logic [13:0] ppu_addr_t;  // PPU address bus
	typedef logic [21:0] mem_addr_t;  // Physical cartridge address
	typedef logic [7:0]  prg_bank_t;  // PRG 8 kB bank number
	typedef logic [9:0]  chr_bank_t;  // CHR 1 kB page number
	typedef logic [7:0]  scanline_t;

	// PRG window sizes; the CHR side reads the same codes as 8k/4k/2k/1k
	typedef enum logic [1:0] {
		MODE_32K    = 2'd0,
		MODE_16K    = 2'd1,
		MODE_16K_8K = 2'd2,
		MODE_8K     = 2'd3
	} bank_mode_t;

	// Nametable source, one 2-bit field per nametable
	typedef enum logic [1:0] {
		NT_CIRAM_A = 2'd0,
		NT_CIRAM_B = 2'd1,
		NT_EXRAM   = 2'd2,  // No ExRAM here, VRAM is simply turned off
		NT_FILL    = 2'd3
	} nt_src_t;

	localparam cpu_addr_t REG_PRG_MODE  = 16'h5100;
	localparam cpu_addr_t REG_CHR_MODE  = 16'h5101;
	localparam cpu_addr_t REG_PROTECT1  = 16'h5102;
	localparam cpu_addr_t REG_PROTECT2  = 16'h5103;
	localparam cpu_addr_t REG_MIRROR    = 16'h5105;
	localparam cpu_addr_t REG_PRG_RAM   = 16'h5113;
	localparam cpu_addr_t REG_PRG_BANK0 = 16'h5114;  // $5114-$5117
	localparam cpu_addr_t REG_CHR_BANK0 = 16'h5120;  // $5120-$5127
	localparam cpu_addr_t REG_CHR_UPPER = 16'h5130;
	localparam cpu_addr_t REG_IRQ_LINE  = 16'h5203;
	localparam cpu_addr_t REG_IRQ_STAT  = 16'h5204;
	localparam cpu_addr_t REG_MUL_LO    = 16'h5205;
	localparam cpu_addr_t REG_MUL_HI    = 16'h5206;

	localparam scanline_t LAST_SCANLINE = 8'd239;
	localparam int NT_MATCH_COUNT   = 3;   // Identical NT reads before a line counts
	localparam int IDLE_EXIT_CYCLES = 64;  // clk cycles without a PPU read
	localparam logic [5:0] PRG_RAM_BASE = 6'b111100;

endpackage

/* logic/mmc5_cfg_if.sv */
// Decoded MMC5 register state fanned out to the mappers and scanline unit
`timescale 1ns/1ps

interface mmc5_cfg_if;
	import mmc5_pkg::*;

	bank_mode_t prg_mode;
	bank_mode_t chr_mode;
	prg_bank_t  prg_bank [4];  // Entry 3 always has bit 7 set
	logic [2:0] prg_ram_bank;
	logic       prg_ram_we;    // Both protect registers unlocked
	chr_bank_t  chr_bank [8];
	nt_src_t    mirroring [4];
	scanline_t  irq_line;

	modport regs (
		output prg_mode, chr_mode, prg_bank, prg_ram_bank, prg_ram_we,
		output chr_bank, mirroring, irq_line
	);
	modport prg (input prg_mode, prg_bank, prg_ram_bank, prg_ram_we);
	modport chr (input chr_mode, chr_bank, mirroring);
	modport scan (input irq_line);

endinterface

/* logic/mmc5_regs.sv */
// MMC5 register file behind a Wishbone classic slave, with multiplier and IRQ status
`timescale 1ns/1ps

module mmc5_regs (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  mmc5_pkg::cpu_addr_t wb_adr_i,
	input  mmc5_pkg::cpu_data_t wb_dat_i,
	output mmc5_pkg::cpu_data_t wb_dat_o,
	output logic                wb_ack_o,
	mmc5_cfg_if.regs            cfg,
	input  logic                in_frame_i,
	input  logic                irq_pending_i,
	output logic                stat_read_o,
	output logic                irq_o
);
	import mmc5_pkg::*;

	bank_mode_t prg_mode, chr_mode;
	logic       protect1_ok, protect2_ok;
	nt_src_t    mirroring [4];
	logic [2:0] prg_ram_bank;
	prg_bank_t  prg_bank [4];
	chr_bank_t  chr_bank [8];
	logic [1:0] chr_upper;     // Latched by $5130, applied on CHR bank writes
	scanline_t  irq_line;
	logic       irq_en;
	cpu_data_t  mul_a, mul_b;
	logic [15:0] product;
	logic       wb_req;

	assign wb_req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // New access, not yet acked
	assign product = mul_a * mul_b;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_ack_o     <= 1'b0;
			stat_read_o  <= 1'b0;
			prg_mode     <= MODE_8K;
			chr_mode     <= MODE_32K;
			protect1_ok  <= 1'b0;
			protect2_ok  <= 1'b0;
			mirroring    <= '{default: NT_CIRAM_A};
			prg_ram_bank <= '0;
			prg_bank     <= '{8'h00, 8'h00, 8'h00, 8'hFF};  // Last bank at $E000 on boot
			chr_bank     <= '{default: '0};
			chr_upper    <= '0;
			irq_line     <= '0;
			irq_en       <= 1'b0;
			mul_a        <= '0;
			mul_b        <= '0;
		end else begin
			wb_ack_o    <= wb_req;
			stat_read_o <= wb_req & ~wb_we_i & (wb_adr_i == REG_IRQ_STAT);
			if (wb_req && wb_we_i) begin
				case (wb_adr_i)
					REG_PRG_MODE:  prg_mode <= bank_mode_t'(wb_dat_i[1:0]);
					REG_CHR_MODE:  chr_mode <= bank_mode_t'(wb_dat_i[1:0]);
					REG_PROTECT1:  protect1_ok <= (wb_dat_i[1:0] == 2'b10);
					REG_PROTECT2:  protect2_ok <= (wb_dat_i[1:0] == 2'b01);
					REG_MIRROR: begin
						for (int i = 0; i < 4; i++)
							mirroring[i] <= nt_src_t'(wb_dat_i[2*i +: 2]);
					end
					REG_PRG_RAM:   prg_ram_bank <= wb_dat_i[2:0];
					REG_CHR_UPPER: chr_upper <= wb_dat_i[1:0];
					REG_IRQ_LINE:  irq_line <= wb_dat_i;
					REG_IRQ_STAT:  irq_en <= wb_dat_i[7];
					REG_MUL_LO:    mul_a <= wb_dat_i;
					REG_MUL_HI:    mul_b <= wb_dat_i;
					default: ;
				endcase

				// $5114-$5117, bank 3 is always ROM
				if (wb_adr_i[15:2] == REG_PRG_BANK0[15:2]) begin
					if (wb_adr_i[1:0] == 2'd3)
						prg_bank[3] <= {1'b1, wb_dat_i[6:0]};
					else
						prg_bank[wb_adr_i[1:0]] <= wb_dat_i;
				end

				if (wb_adr_i[15:3] == REG_CHR_BANK0[15:3])
					chr_bank[wb_adr_i[2:0]] <= {chr_upper, wb_dat_i};
			end
		end
	end

	// Read data, valid while ack is high
	always_comb begin
		case (wb_adr_i)
			REG_IRQ_STAT: wb_dat_o = {irq_pending_i, in_frame_i, 6'b111111};
			REG_MUL_LO:   wb_dat_o = product[7:0];
			REG_MUL_HI:   wb_dat_o = product[15:8];
			default:      wb_dat_o = 8'hFF;  // Open bus
		endcase
	end

	assign irq_o = irq_pending_i & irq_en;

	assign cfg.prg_mode     = prg_mode;
	assign cfg.chr_mode     = chr_mode;
	assign cfg.prg_bank     = prg_bank;
	assign cfg.prg_ram_bank = prg_ram_bank;
	assign cfg.prg_ram_we   = protect1_ok & protect2_ok;
	assign cfg.chr_bank     = chr_bank;
	assign cfg.mirroring    = mirroring;
	assign cfg.irq_line     = irq_line;

	// Master must hold stb through the ack cycle
	a_ack_with_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
		wb_ack_o |-> wb_stb_i)
		else $error("wb_ack_o high without wb_stb_i");

endmodule

/* logic/mmc5_prg_map.sv */
// PRG address translation into 8 kB pages and PRG access permission
`timescale 1ns/1ps

module mmc5_prg_map (
	input  mmc5_pkg::cpu_addr_t wb_adr_i,
	input  logic                wb_we_i,
	mmc5_cfg_if.prg             cfg,
	output mmc5_pkg::mem_addr_t prg_addr_o,
	output logic                prg_allow_o
);
	import mmc5_pkg::*;

	logic [6:0] page;    // 8 kB ROM page
	logic       is_ram;  // $6000-$7FFF

	assign is_ram = (wb_adr_i[15:13] == 3'b011);

	always_comb begin
		case (cfg.prg_mode)
			MODE_32K: page = {cfg.prg_bank[3][6:2], wb_adr_i[14:13]};
			MODE_16K: begin
				if (wb_adr_i[14])
					page = {cfg.prg_bank[3][6:1], wb_adr_i[13]};  // $C000-$FFFF
				else
					page = {cfg.prg_bank[1][6:1], wb_adr_i[13]};  // $8000-$BFFF
			end
			MODE_16K_8K: begin
				case (wb_adr_i[14:13])
					2'b10:   page = cfg.prg_bank[2][6:0];
					2'b11:   page = cfg.prg_bank[3][6:0];
					default: page = {cfg.prg_bank[1][6:1], wb_adr_i[13]};
				endcase
			end
			default: page = cfg.prg_bank[wb_adr_i[14:13]][6:0];  // Four 8 kB windows
		endcase
	end

	assign prg_addr_o = is_ram ? {PRG_RAM_BASE, cfg.prg_ram_bank, wb_adr_i[12:0]}
	                           : {2'b00, page, wb_adr_i[12:0]};

	// Reads anywhere from $6000 up, writes only into unlocked RAM
	assign prg_allow_o = (wb_adr_i >= 16'h6000) && (!wb_we_i || (is_ram && cfg.prg_ram_we));

endmodule

/* logic/mmc5_chr_map.sv */
// CHR address translation into 1 kB pages and nametable mirroring to internal VRAM
`timescale 1ns/1ps

module mmc5_chr_map (
	input  mmc5_pkg::ppu_addr_t chr_addr_i,
	mmc5_cfg_if.chr             cfg,
	output mmc5_pkg::mem_addr_t chr_addr_o,
	output logic                vram_a10_o,
	output logic                vram_ce_o
);
	import mmc5_pkg::*;

	chr_bank_t page;
	nt_src_t   nt;  // Field for the addressed nametable

	always_comb begin
		case (cfg.chr_mode)
			// 8 kB from bank 7
			MODE_32K:    page = {cfg.chr_bank[7][9:3], chr_addr_i[12:10]};
			// 4 kB, banks 3 and 7
			MODE_16K:    page = {cfg.chr_bank[{chr_addr_i[12], 2'b11}][9:2], chr_addr_i[11:10]};
			// 2 kB, banks 1, 3, 5 and 7
			MODE_16K_8K: page = {cfg.chr_bank[{chr_addr_i[12:11], 1'b1}][9:1], chr_addr_i[10]};
			default:     page = cfg.chr_bank[chr_addr_i[12:10]];
		endcase
	end

	assign chr_addr_o = {2'b10, page, chr_addr_i[9:0]};

	assign nt = cfg.mirroring[chr_addr_i[11:10]];

	assign vram_a10_o = nt[0];
	assign vram_ce_o  = chr_addr_i[13] & ~nt[1];  // ExRAM and fill codes disable VRAM

endmodule

/* logic/mmc5_scanline.sv */
// In-frame and scanline detection from repeated nametable reads, with IRQ pending flag
`timescale 1ns/1ps

module mmc5_scanline (
	input  logic                clk,
	input  logic                arst_n_i,
	input  mmc5_pkg::ppu_addr_t chr_addr_i,
	input  logic                chr_rd_i,
	mmc5_cfg_if.scan            cfg,
	input  logic                stat_read_i,
	output logic                in_frame_o,
	output logic                irq_pending_o
);
	import mmc5_pkg::*;

	logic        rd_q;
	logic [11:0] nt_addr_q;  // Offset of the previous read
	logic [$clog2(NT_MATCH_COUNT+1)-1:0]  nt_cnt;
	logic [$clog2(IDLE_EXIT_CYCLES)-1:0] idle_cnt;
	scanline_t   scanline, next_line;
	logic        rd_edge, is_nt, hit, enter, leave, line_inc;

	assign rd_edge   = chr_rd_i & ~rd_q;
	assign is_nt     = (chr_addr_i[13:12] == 2'b10);  // $2000-$2FFF
	assign next_line = scanline + 1'b1;

	// Read after a full run of matches, its address does not matter
	assign hit      = rd_edge && (nt_cnt == NT_MATCH_COUNT);
	assign enter    = hit && !in_frame_o;
	assign line_inc = hit && in_frame_o && (scanline != LAST_SCANLINE);
	assign leave    = (hit && in_frame_o && scanline == LAST_SCANLINE) ||
	                  (in_frame_o && !chr_rd_i && idle_cnt == IDLE_EXIT_CYCLES - 1);

	always_ff @(posedge clk) begin
		if (rd_edge)
			nt_addr_q <= chr_addr_i[11:0];
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_q          <= 1'b0;
			nt_cnt        <= '0;
			idle_cnt      <= '0;
			scanline      <= '0;
			in_frame_o    <= 1'b0;
			irq_pending_o <= 1'b0;
		end else begin
			rd_q     <= chr_rd_i;
			idle_cnt <= (chr_rd_i || !in_frame_o) ? '0 : idle_cnt + 1'b1;

			if (leave || hit)
				nt_cnt <= '0;
			else if (rd_edge) begin
				if (!is_nt)
					nt_cnt <= '0;
				else if (nt_cnt == 0 || nt_addr_q == chr_addr_i[11:0])
					nt_cnt <= nt_cnt + 1'b1;
				else
					nt_cnt <= 1;  // New address starts a new run
			end

			if (leave)
				in_frame_o <= 1'b0;
			else if (enter)
				in_frame_o <= 1'b1;

			if (enter)
				scanline <= '0;
			else if (line_inc)
				scanline <= next_line;

			if (leave)
				irq_pending_o <= 1'b0;
			else if (line_inc && next_line == cfg.irq_line)
				irq_pending_o <= 1'b1;
			else if (stat_read_i)
				irq_pending_o <= 1'b0;  // Cleared by a $5204 read
		end
	end

	a_scanline_range: assert property (@(posedge clk) disable iff (!arst_n_i)
		scanline <= LAST_SCANLINE)
		else $error("scanline beyond LAST_SCANLINE");

endmodule

/* logic/mmc5_top.sv */
// MMC5 banking and scanline core, CPU side on Wishbone classic
`timescale 1ns/1ps

module mmc5_top (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  mmc5_pkg::cpu_addr_t wb_adr_i,
	input  mmc5_pkg::cpu_data_t wb_dat_i,
	output mmc5_pkg::cpu_data_t wb_dat_o,
	output logic                wb_ack_o,
	input  mmc5_pkg::ppu_addr_t chr_addr_i,
	input  logic                chr_rd_i,
	output mmc5_pkg::mem_addr_t prg_addr_o,
	output logic                prg_allow_o,
	output mmc5_pkg::mem_addr_t chr_addr_o,
	output logic                vram_a10_o,
	output logic                vram_ce_o,
	output logic                irq_o
);

	logic in_frame;
	logic irq_pending;
	logic stat_read;

	mmc5_cfg_if cfg_bus ();

	mmc5_regs u_regs (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.cfg           (cfg_bus.regs),
		.in_frame_i    (in_frame),
		.irq_pending_i (irq_pending),
		.stat_read_o   (stat_read),
		.irq_o         (irq_o)
	);

	mmc5_prg_map u_prg_map (
		.wb_adr_i    (wb_adr_i),
		.wb_we_i     (wb_we_i),
		.cfg         (cfg_bus.prg),
		.prg_addr_o  (prg_addr_o),
		.prg_allow_o (prg_allow_o)
	);

	mmc5_chr_map u_chr_map (
		.chr_addr_i (chr_addr_i),
		.cfg        (cfg_bus.chr),
		.chr_addr_o (chr_addr_o),
		.vram_a10_o (vram_a10_o),
		.vram_ce_o  (vram_ce_o)
	);

	mmc5_scanline u_scanline (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.chr_addr_i    (chr_addr_i),
		.chr_rd_i      (chr_rd_i),
		.cfg           (cfg_bus.scan),
		.stat_read_i   (stat_read),
		.in_frame_o    (in_frame),
		.irq_pending_o (irq_pending)
	);

endmodule

/* bench/tb_mmc5.sv */
// Directed testbench for the MMC5 banking and scanline core
`timescale 1ns/1ps

module tb_mmc5;
	import mmc5_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int WATCHDOG_NS  = 20000;  // Tests take about 400 clk cycles of 4 ns

	logic        clk;
	logic        arst_n_i;
	logic        wb_cyc_i, wb_stb_i, wb_we_i;
	cpu_addr_t   wb_adr_i;
	cpu_data_t   wb_dat_i, wb_dat_o;
	logic        wb_ack_o;
	ppu_addr_t   chr_addr_i;
	logic        chr_rd_i;
	mem_addr_t   prg_addr_o, chr_addr_o;
	logic        prg_allow_o, vram_a10_o, vram_ce_o, irq_o;
	int          errors, checks;
	logic [7:0]  prg_bank [4];  // Bank bytes as written
	logic [9:0]  chr_bank [8];  // Upper bits from $5130 above the written byte

	mmc5_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: tests did not complete within %0d ns", WATCHDOG_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] expected,
	                     input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Next drive point 1 ns after a rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic bus_access(input logic we, input cpu_addr_t addr, input cpu_data_t wdata,
	                          output cpu_data_t rdata);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = addr;
		wb_dat_i = wdata;
		@(negedge clk);
		while (!wb_ack_o)
			@(negedge clk);
		rdata = wb_dat_o;  // Valid while ack is high
		step();
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic wb_write(input cpu_addr_t addr, input cpu_data_t data);
		cpu_data_t unused;
		bus_access(1'b1, addr, data, unused);
	endtask

	task automatic wb_read(input cpu_addr_t addr, output cpu_data_t data);
		bus_access(1'b0, addr, 8'h00, data);
	endtask

	task automatic ppu_read(input ppu_addr_t addr);
		chr_addr_i = addr;
		chr_rd_i   = 1'b1;
		step();
		chr_rd_i = 1'b0;
		step();
	endtask

	// Expected 8 kB ROM page for a CPU address in $8000-$FFFF
	function automatic logic [6:0] prg_page(input int mode, input cpu_addr_t addr);
		logic [1:0] win;
		win = addr[14:13];
		case (mode)
			0:       return {prg_bank[3][6:2], win};
			1:       return {prg_bank[win[1] ? 3 : 1][6:1], win[0]};
			2:       return win[1] ? prg_bank[win][6:0] : {prg_bank[1][6:1], win[0]};
			default: return prg_bank[win][6:0];
		endcase
	endfunction

	// Expected 1 kB CHR page, sel is PPU A12-A10
	function automatic logic [9:0] chr_page(input int mode, input logic [2:0] sel);
		case (mode)
			0:       return {chr_bank[7][9:3], sel};
			1:       return {chr_bank[sel[2] ? 7 : 3][9:2], sel[1:0]};
			2:       return {chr_bank[{sel[2:1], 1'b1}][9:1], sel[0]};
			default: return chr_bank[sel];
		endcase
	endfunction

	task automatic reset_defaults();
		cpu_data_t stat;
		wb_adr_i = 16'hE123;
		@(negedge clk);
		check("reset_defaults rom addr", {2'b00, 7'h7F, 13'h0123}, prg_addr_o);
		check("reset_defaults irq", 1'b0, irq_o);
		step();
		wb_read(REG_IRQ_STAT, stat);
		check("reset_defaults status", 8'h3F, stat);
	endtask

	task automatic multiplier_product();
		cpu_data_t   a, b, rd;
		logic [15:0] prod;
		repeat (4) begin
			a    = 8'($urandom);
			b    = 8'($urandom);
			prod = a * b;
			wb_write(REG_MUL_LO, a);
			wb_write(REG_MUL_HI, b);
			wb_read(REG_MUL_LO, rd);
			check("multiplier_product low", prod[7:0], rd);
			wb_read(REG_MUL_HI, rd);
			check("multiplier_product high", prod[15:8], rd);
		end
	endtask

	task automatic prg_banking();
		cpu_addr_t  addr;
		logic [2:0] ram_bank;
		for (int mode = 0; mode < 4; mode++) begin
			wb_write(REG_PRG_MODE, 8'(mode));
			for (int i = 0; i < 4; i++) begin
				prg_bank[i] = 8'($urandom);
				wb_write(REG_PRG_BANK0 + 16'(i), prg_bank[i]);
			end
			for (int w = 0; w < 4; w++) begin  // One address per 8 kB window
				addr     = {1'b1, 2'(w), 13'($urandom)};
				wb_adr_i = addr;
				@(negedge clk);
				check("prg_banking rom addr", {2'b00, prg_page(mode, addr), addr[12:0]},
				      prg_addr_o);
				check("prg_banking read allow", 1'b1, prg_allow_o);
				step();
			end
		end
		ram_bank = 3'($urandom);
		wb_write(REG_PRG_RAM, {5'b0, ram_bank});
		wb_write(REG_PROTECT1, 8'h02);
		wb_write(REG_PROTECT2, 8'h00);
		addr     = {3'b011, 13'($urandom)};
		wb_adr_i = addr;
		wb_we_i  = 1'b1;
		@(negedge clk);
		check("prg_banking ram addr", {PRG_RAM_BASE, ram_bank, addr[12:0]}, prg_addr_o);
		check("prg_banking ram locked", 1'b0, prg_allow_o);
		step();
		wb_write(REG_PROTECT2, 8'h01);
		wb_adr_i = addr;
		wb_we_i  = 1'b1;
		@(negedge clk);
		check("prg_banking ram unlocked", 1'b1, prg_allow_o);
		wb_adr_i = 16'h9000;  // ROM stays read only
		#0.5;
		check("prg_banking rom write", 1'b0, prg_allow_o);
		step();
		wb_we_i = 1'b0;
		wb_write(REG_PROTECT1, 8'h00);  // Second key alone does not unlock
		wb_adr_i = addr;
		wb_we_i  = 1'b1;
		@(negedge clk);
		check("prg_banking ram relocked", 1'b0, prg_allow_o);
		step();
		wb_we_i = 1'b0;
	endtask

	task automatic chr_banking();
		cpu_data_t upper, data;
		ppu_addr_t addr;
		for (int mode = 0; mode < 4; mode++) begin
			upper = 8'($urandom);
			wb_write(REG_CHR_MODE, 8'(mode));
			wb_write(REG_CHR_UPPER, upper);
			for (int i = 0; i < 8; i++) begin
				data        = 8'($urandom);
				chr_bank[i] = {upper[1:0], data};
				wb_write(REG_CHR_BANK0 + 16'(i), data);
			end
			for (int s = 0; s < 8; s++) begin
				addr       = {1'b0, 3'(s), 10'($urandom)};
				chr_addr_i = addr;
				@(negedge clk);
				check("chr_banking addr", {2'b10, chr_page(mode, 3'(s)), addr[9:0]}, chr_addr_o);
				step();
			end
		end
	endtask

	task automatic nametable_mirroring();
		cpu_data_t mirror;
		repeat (4) begin
			mirror = 8'($urandom);
			wb_write(REG_MIRROR, mirror);
			for (int nt = 0; nt < 4; nt++) begin
				chr_addr_i = {2'b10, 2'(nt), 10'($urandom)};
				@(negedge clk);
				check("nametable_mirroring a10", mirror[2*nt], vram_a10_o);
				check("nametable_mirroring ce", !mirror[2*nt+1], vram_ce_o);
				step();
			end
		end
		chr_addr_i = {1'b0, 13'($urandom)};  // Pattern fetch never selects VRAM
		@(negedge clk);
		check("nametable_mirroring pattern ce", 1'b0, vram_ce_o);
		step();
	endtask

	task automatic scanline_irq();
		cpu_data_t stat;
		ppu_addr_t addr;
		int        line;
		line = 2 + ($urandom % 5);
		wb_write(REG_IRQ_LINE, 8'(line));
		wb_write(REG_IRQ_STAT, 8'h80);
		// First group enters the frame and each later group counts one line
		for (int g = 0; g <= line; g++) begin
			check("scanline_irq early", 1'b0, irq_o);
			addr = {2'b10, 12'($urandom)};
			repeat (4)
				ppu_read(addr);
		end
		check("scanline_irq raised", 1'b1, irq_o);
		wb_read(REG_IRQ_STAT, stat);
		check("scanline_irq pending bit", 1'b1, stat[7]);
		check("scanline_irq in frame bit", 1'b1, stat[6]);
		check("scanline_irq cleared", 1'b0, irq_o);
		repeat (IDLE_EXIT_CYCLES + 8)
			step();
		wb_read(REG_IRQ_STAT, stat);
		check("scanline_irq idle exit", 8'h3F, stat);
	endtask

	initial begin
		void'($urandom(32'h7ec2));
		errors     = 0;
		checks     = 0;
		arst_n_i   = 1'b0;
		wb_cyc_i   = 1'b0;
		wb_stb_i   = 1'b0;
		wb_we_i    = 1'b0;
		wb_adr_i   = '0;
		wb_dat_i   = '0;
		chr_addr_i = '0;
		chr_rd_i   = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		#1;
		arst_n_i = 1'b1;
		step();
		reset_defaults();
		multiplier_product();
		prg_banking();
		chr_banking();
		nametable_mirroring();
		scanline_irq();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* tb.f */
logic/mmc5_pkg.sv
logic/mmc5_cfg_if.sv
logic/mmc5_regs.sv
logic/mmc5_prg_map.sv
logic/mmc5_chr_map.sv
logic/mmc5_scanline.sv
logic/mmc5_top.sv
bench/tb_mmc5.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mmc5
FILELIST  = tb.f
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf obj_dir
